// File: src.f
+incdir+hdl
+incdir+testbench
hdl/cur_buf_pkg.sv
hdl/cur_fetch_ctrl.sv
hdl/cur_pingpong_buf.sv
hdl/cur_row_blend.sv
hdl/cur_buffer.sv
testbench/tb_cur_buffer.sv

// File: run.sh
#!/bin/sh
# build and run the cur_buffer testbench with Verilator
# exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

TOP=tb_cur_buffer
OBJ=obj_dir

verilator --binary --timing \
    --top-module "$TOP" \
    --Mdir "$OBJ" \
    -f src.f
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit "$status"
fi

if [ ! -x "./$OBJ/V$TOP" ]; then
    echo "simulation binary ./$OBJ/V$TOP not found"
    exit 1
fi

"./$OBJ/V$TOP"
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

exit 0

// File: testbench/tb_cur_buffer_checks.svh
`ifndef TB_CUR_BUFFER_CHECKS_SVH
`define TB_CUR_BUFFER_CHECKS_SVH

// 32-bit LCG for the memory contents
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

task automatic check_block(input string name, input cb_block_t exp, input cb_block_t act);
    if (act !== exp) begin
        $display("FAILED %s: cur_out expected %h actual %h", name, exp, act);
        $display(">>> FAIL");
        $fatal(1, "cur_out differs from the expected block");
    end
endtask

// valid is covered by check_bit, this one looks at the address
task automatic check_req(input string name, input cb_mem_req_t exp, input cb_mem_req_t act);
    if (act.addr !== exp.addr) begin
        $display("FAILED %s: mem_req expected valid %0b addr %h, actual valid %0b addr %h",
                 name, exp.valid, exp.addr, act.valid, act.addr);
        $display(">>> FAIL");
        $fatal(1, "memory request differs from the expected one");
    end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        $display("FAILED %s: mem_req.valid expected %0b actual %0b", name, exp, act);
        $display(">>> FAIL");
        $fatal(1, "request valid bit differs from the expected one");
    end
endtask

// step until the first cycle with a request, the first step is taken anyway
task automatic wait_req_valid();
    int n;
    n = 0;
    run_cycle(1'b1, 1'b0);
    while (mem_req.valid !== 1'b1) begin
        if (n == WAIT_LIMIT) begin
            $display("test %s: the memory request never appeared within %0d cycles",
                     cur_name, WAIT_LIMIT);
            $display(">>> FAIL");
            $fatal(1, "timeout while waiting for a memory request");
        end
        n++;
        run_cycle(1'b1, 1'b0);
    end
endtask

// step until the fetch has issued its last request
task automatic wait_req_done();
    int n;
    n = 0;
    while (mem_req.valid !== 1'b0) begin
        if (n == WAIT_LIMIT) begin
            $display("test %s: the fetch never finished within %0d cycles",
                     cur_name, WAIT_LIMIT);
            $display(">>> FAIL");
            $fatal(1, "timeout while waiting for the end of a fetch");
        end
        n++;
        run_cycle(1'b1, 1'b0);
    end
endtask

`endif

// File: testbench/tb_cur_buffer.sv
`timescale 1ns/10ps

`include "cur_buf_consts.svh"

module tb_cur_buffer
    import cur_buf_pkg::*;
();

    localparam int MEM_WORDS  = 1024;
    localparam int NUM_TESTS  = 8;
    localparam int WAIT_LIMIT = 100;
    localparam int DROP_LEN   = 4;

    // idle enabled cycles before next_block, and whether en drops afterwards
    typedef struct packed {
        logic [7:0] idle;
        logic       drop;
    } stim_t;

    logic        clk;
    logic        rst;
    logic        en;
    logic        next_block;
    cb_word_t    cur_in = '0;
    cb_mem_req_t mem_req;
    cb_block_t   cur_out;

    cb_word_t    mem [MEM_WORDS];
    cb_mem_req_t req_q = '0;

    // reference model of fetch, display and switchover
    logic                  cold;
    int                    req_left;
    int                    blend_k;
    logic [`CB_ADDR_W-1:0] exp_addr;
    cb_block_t             shown_blk;
    cb_block_t             prev_blk;
    cb_block_t             filled_blk;

    string cur_name;
    int    cycle_cnt;

    string test_names [NUM_TESTS] = '{"second_block", "third_block", "drop_in_switch",
                                      "long_idle", "min_gap", "drop_again",
                                      "after_drop", "final_block"};

    stim_t stim_table [NUM_TESTS] = '{'{8'd2, 1'b0}, '{8'd5, 1'b0}, '{8'd3, 1'b1},
                                      '{8'd40, 1'b0}, '{8'd2, 1'b0}, '{8'd12, 1'b1},
                                      '{8'd7, 1'b0}, '{8'd3, 1'b0}};

    `include "tb_cur_buffer_checks.svh"

    cur_buffer cur_buffer_inst (
        .clk        (clk),
        .rst        (rst),
        .en         (en),
        .next_block (next_block),
        .cur_in     (cur_in),
        .mem_req    (mem_req),
        .cur_out    (cur_out)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    // memory returns the word requested in the previous cycle
    always @(negedge clk) begin
        if (req_q.valid === 1'b1) begin
            cur_in = mem[req_q.addr[11:2]];
        end
        req_q = mem_req;
    end

    // word i of a fetch sits at bit 32*i of the block
    function automatic cb_block_t build_block(input logic [`CB_ADDR_W-1:0] base);
        cb_word_t [`CB_WORDS-1:0] words;
        logic [9:0]               idx;
        for (int i = 0; i < `CB_WORDS; i++) begin
            idx          = base[11:2] + 10'(i);
            words[4'(i)] = mem[idx];
        end
        return words;
    endfunction

    // step k shows rows 0..k of the new block, the rest still old
    function automatic cb_block_t expected_out(input logic en_v);
        cb_block_t blk;
        blk = '0;
        if (en_v) begin
            for (int r = 0; r < `CB_ROWS; r++) begin
                if (blend_k >= 0 && r > blend_k) begin
                    blk[3'(r)] = prev_blk[3'(r)];
                end else begin
                    blk[3'(r)] = shown_blk[3'(r)];
                end
            end
        end
        return blk;
    endfunction

    task automatic advance_model(input logic en_v, input logic nb_v);
        if (en_v) begin
            if (nb_v || cold) begin
                cold       = 1'b0;
                prev_blk   = shown_blk;
                shown_blk  = filled_blk;
                filled_blk = build_block(exp_addr);
                req_left   = `CB_WORDS;
                blend_k    = 0;
            end else begin
                if (req_left > 0) begin
                    exp_addr = exp_addr + `CB_ADDR_STEP;
                    req_left--;
                end
                if (blend_k == `CB_BLEND_CYCLES - 1) begin
                    blend_k = -1;
                end else if (blend_k >= 0) begin
                    blend_k++;
                end
            end
        end
    endtask

    // one clock cycle, inputs on the falling edge and checks 2 ns later
    task automatic run_cycle(input logic en_v, input logic nb_v);
        cb_mem_req_t exp_req;
        string       tag;
        @(negedge clk);
        en         = en_v;
        next_block = nb_v;
        #2;
        tag           = $sformatf("%s cycle %0d", cur_name, cycle_cnt);
        exp_req.valid = (req_left > 0);
        exp_req.addr  = exp_addr;
        check_bit(tag, exp_req.valid, mem_req.valid);
        check_req(tag, exp_req, mem_req);
        check_block(tag, expected_out(en_v), cur_out);
        advance_model(en_v, nb_v);
        cycle_cnt++;
    endtask

    task automatic apply_entry(input string name, input stim_t entry);
        cur_name = name;
        repeat (int'(entry.idle)) run_cycle(1'b1, 1'b0);
        run_cycle(1'b1, 1'b1);
        wait_req_valid();
        if (entry.drop) begin
            // freeze mid switchover and mid fetch, next_block must be ignored
            repeat (2) run_cycle(1'b1, 1'b0);
            repeat (DROP_LEN) run_cycle(1'b0, 1'b1);
        end
        wait_req_done();
    endtask

    initial begin
        logic [31:0] seed;
        rst        = 1'b1;
        en         = 1'b0;
        next_block = 1'b0;
        cold       = 1'b1;
        req_left   = 0;
        blend_k    = -1;
        exp_addr   = '0;
        shown_blk  = '0;
        prev_blk   = '0;
        filled_blk = '0;
        cycle_cnt  = 0;
        cur_name   = "reset";
        seed       = 32'd8;
        for (int i = 0; i < MEM_WORDS; i++) begin
            seed        = lcg_next(seed);
            mem[10'(i)] = seed;
        end

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        cur_name = "after_reset";
        repeat (3) run_cycle(1'b0, 1'b0);

        // first enabled cycle starts the cold-boot fetch
        cur_name = "cold_boot";
        wait_req_valid();
        wait_req_done();

        for (int t = 0; t < NUM_TESTS; t++) begin
            apply_entry(test_names[3'(t)], stim_table[3'(t)]);
        end

        cur_name = "drain";
        repeat (10) run_cycle(1'b1, 1'b0);

        $display(">>> PASS");
        $finish;
    end

endmodule

// File: hdl/cur_buffer.sv
`timescale 1ns/10ps

module cur_buffer
    import cur_buf_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        en,
    input  logic        next_block,
    input  cb_word_t    cur_in,
    output cb_mem_req_t mem_req,
    output cb_block_t   cur_out
);

    logic      start;
    cb_wr_t    wr;
    cb_block_t new_block;
    cb_block_t old_block;

    // fetch sequencing and the start pulse shared by both other stages
    cur_fetch_ctrl cur_fetch_ctrl_inst (
        .clk        (clk),
        .rst        (rst),
        .en         (en),
        .next_block (next_block),
        .start      (start),
        .mem_req    (mem_req),
        .wr         (wr)
    );

    // ping-pong storage, one bank displayed while the other fills
    cur_pingpong_buf cur_pingpong_buf_inst (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .wr        (wr),
        .cur_in    (cur_in),
        .new_block (new_block),
        .old_block (old_block)
    );

    // output rows move to the new block one per cycle
    cur_row_blend cur_row_blend_inst (
        .clk       (clk),
        .rst       (rst),
        .en        (en),
        .start     (start),
        .new_block (new_block),
        .old_block (old_block),
        .cur_out   (cur_out)
    );

endmodule

// File: hdl/cur_row_blend.sv
`timescale 1ns/10ps

`include "cur_buf_consts.svh"

module cur_row_blend
    import cur_buf_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      en,
    input  logic      start,
    input  cb_block_t new_block,
    input  cb_block_t old_block,
    output cb_block_t cur_out
);

    localparam logic [`CB_STEP_W-1:0] LAST_STEP = `CB_STEP_W'(`CB_BLEND_CYCLES - 1);

    logic                  blending;
    logic [`CB_STEP_W-1:0] step;

    // step k of the switchover shows rows 0..k from the new block
    always_ff @(posedge clk) begin
        if (rst) begin
            blending <= 1'b0;
            step     <= '0;
        end else if (en) begin
            if (start) begin
                blending <= 1'b1;
                step     <= '0;
            end else if (blending) begin
                if (step == LAST_STEP) begin
                    blending <= 1'b0;
                    step     <= '0;
                end else begin
                    step <= step + 1'b1;
                end
            end
        end
    end

    // per-row select, rows above the step still show the old block
    always_comb begin
        cur_out = '0;
        if (en) begin
            for (int r = 0; r < `CB_ROWS; r++) begin
                if (blending && (r > int'(step))) begin
                    cur_out[r] = old_block[r];
                end else begin
                    cur_out[r] = new_block[r];
                end
            end
        end
    end

endmodule

// File: hdl/cur_pingpong_buf.sv
`timescale 1ns/10ps

`include "cur_buf_consts.svh"

module cur_pingpong_buf
    import cur_buf_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  cb_wr_t    wr,
    input  cb_word_t  cur_in,
    output cb_block_t new_block,
    output cb_block_t old_block
);

    // each bank is sixteen words, word i at bit 32*i as in cb_block_t
    cb_word_t [`CB_WORDS-1:0] bank [2];

    // bank shown as the current block
    logic sel;

    always_ff @(posedge clk) begin
        if (rst) begin
            sel <= 1'b0;
        end else if (start) begin
            sel <= ~sel;
        end
    end

    // incoming words always fill the bank that is not on display
    always_ff @(posedge clk) begin
        if (rst) begin
            bank[0] <= '0;
            bank[1] <= '0;
        end else if (wr.en) begin
            bank[~sel][wr.idx] <= cur_in;
        end
    end

    // after a swap, new_block is the bank the previous fetch filled
    always_comb begin
        new_block = bank[sel];
        old_block = bank[~sel];
    end

endmodule

// File: hdl/cur_fetch_ctrl.sv
`timescale 1ns/10ps

`include "cur_buf_consts.svh"

module cur_fetch_ctrl
    import cur_buf_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        en,
    input  logic        next_block,
    output logic        start,
    output cb_mem_req_t mem_req,
    output cb_wr_t      wr
);

    localparam logic [`CB_WIDX_W-1:0] LAST_WORD = `CB_WIDX_W'(`CB_WORDS - 1);
    localparam logic [`CB_ADDR_W-1:0] ADDR_STEP = `CB_ADDR_W'(`CB_ADDR_STEP);

    logic                  cold_boot;
    logic                  rd_en;
    logic [`CB_WIDX_W-1:0] word_cnt;
    logic [`CB_ADDR_W-1:0] rd_addr;

    // the only place the start condition is decoded
    // the first enabled cycle after reset always starts a fetch
    assign start = en && (next_block || cold_boot);

    always_ff @(posedge clk) begin
        if (rst) begin
            cold_boot <= 1'b1;
            rd_en     <= 1'b0;
            word_cnt  <= '0;
            rd_addr   <= '0;
        end else if (en) begin
            if (start) begin
                // restart from word 0, the address keeps running
                cold_boot <= 1'b0;
                rd_en     <= 1'b1;
                word_cnt  <= '0;
            end else if (rd_en) begin
                rd_addr <= rd_addr + ADDR_STEP;
                if (word_cnt == LAST_WORD) begin
                    rd_en <= 1'b0;
                end else begin
                    word_cnt <= word_cnt + 1'b1;
                end
            end
        end
    end

    always_comb begin
        mem_req.valid = rd_en;
        mem_req.addr  = rd_addr;
    end

    // memory answers one cycle after the request
    // so the write side sees valid and index one cycle late
    // this stage runs even while en is low
    always_ff @(posedge clk) begin
        if (rst) begin
            wr <= '0;
        end else begin
            wr.en  <= rd_en;
            wr.idx <= word_cnt;
        end
    end

endmodule

// File: hdl/cur_buf_pkg.sv
`include "cur_buf_consts.svh"

package cur_buf_pkg;

    // one 64-bit row of eight pixels, pixel 0 in the low byte
    typedef logic [`CB_ROW_PIX-1:0][`CB_PIX_W-1:0] cb_row_t;

    // row 0 is least significant
    // fetch word i lands at bit 32*i, so row r holds words 2r and 2r+1
    typedef cb_row_t [`CB_ROWS-1:0] cb_block_t;

    // one memory word of four pixels
    typedef logic [`CB_WORD_PIX-1:0][`CB_PIX_W-1:0] cb_word_t;

    // read request towards memory, answered one cycle later
    typedef struct packed {
        logic                  valid;
        logic [`CB_ADDR_W-1:0] addr;
    } cb_mem_req_t;

    // write port into the inactive bank, aligned with the returning word
    typedef struct packed {
        logic                  en;
        logic [`CB_WIDX_W-1:0] idx;
    } cb_wr_t;

endpackage

// File: hdl/cur_buf_consts.svh
`ifndef CUR_BUF_CONSTS_SVH
`define CUR_BUF_CONSTS_SVH

// pixel and memory word geometry
`define CB_PIX_W        8
`define CB_WORD_W       32
`define CB_WORD_PIX     (`CB_WORD_W / `CB_PIX_W)

// block geometry, 8x8 pixels
`define CB_ROW_W        64
`define CB_ROW_PIX      (`CB_ROW_W / `CB_PIX_W)
`define CB_ROWS         8
`define CB_WORDS        16
`define CB_WIDX_W       4

// memory side, byte addressed
`define CB_ADDR_W       32
`define CB_ADDR_STEP    4

// row-by-row switchover to a new block
`define CB_BLEND_CYCLES 7
`define CB_STEP_W       3

`endif
